/* all.f */
logic/conv_pkg.sv
logic/beat_if.sv
logic/block_quantizer.sv
logic/lane_ram.sv
logic/block_to_row_buffer.sv
logic/row_summer.sv
logic/b2r_top.sv
testbench/b2r_assert.sv
testbench/b2r_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module b2r_tb -f all.f -o b2r_sim \
    && ./obj_dir/b2r_sim \
    || { echo "Build or simulation failed"; exit 1; }

/* testbench/b2r_tb.sv */
// Testbench for the block to row converter
// LFSR stimulus, reference rows, row compare and watchdog
`timescale 1ns/1ps
`default_nettype none

module b2r_tb;
    import conv_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int RST_CYCLES = 2;
    localparam int NUM_MATS   = 13;
    localparam int LIMIT_MATS = 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_first;
    logic        in_last;
    in_block_t   in_block;
    logic        out_valid;
    row_t        out_row;
    sum_t        out_sum;
    row_idx_t    out_index;
    logic        out_last;

    logic [31:0] lfsr_state = 32'hf6f;
    in_elem_t    mat_in [MAT_N][MAT_N];
    row_t        exp_rows [$];
    sum_t        exp_sums [$];
    row_idx_t    exp_idx [$];

    b2r_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_last   (in_last),
        .in_block  (in_block),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_sum   (out_sum),
        .out_index (out_index),
        .out_last  (out_last)
    );

    initial begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd0000001;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // Round half up to the output LSB and clamp to 16 bits
    function automatic elem_t quantize_ref(input in_elem_t x);
        int v;
        v = (int'(x) + 128) >>> FRAC_SHIFT;
        if (v > 32767) begin
            v = 32767;
        end else if (v < -32768) begin
            v = -32768;
        end
        return elem_t'(v);
    endfunction

    function automatic void build_expected();
        row_t exp_row;
        int   total;
        for (int r = 0; r < MAT_N; r++) begin
            total = 0;
            for (int c = 0; c < MAT_N; c++) begin
                exp_row[c] = quantize_ref(mat_in[r][c]);
                total += int'(exp_row[c]);
            end
            exp_rows.push_back(exp_row);
            exp_sums.push_back(sum_t'(total));
            exp_idx.push_back(row_idx_t'(r));
        end
    endfunction

    // Ties, negatives and values that round past the top of the range
    function automatic void fill_directed();
        in_elem_t edge_vals [16];
        edge_vals = '{24'h7fffff, 24'h7fff80, 24'h7fff7f, 24'h000080,
                      24'h00007f, 24'h000180, 24'hffff80, 24'hffff7f,
                      24'hfffe80, 24'h800000, 24'h800001, 24'h80007f,
                      24'h000000, 24'h123456, 24'hfedcba, 24'h400000};
        for (int r = 0; r < MAT_N; r++) begin
            for (int c = 0; c < MAT_N; c++) begin
                mat_in[r][c] = edge_vals[(r * MAT_N + c + r) % 16];
            end
        end
    endfunction

    function automatic void fill_random();
        for (int r = 0; r < MAT_N; r++) begin
            for (int c = 0; c < MAT_N; c++) begin
                mat_in[r][c] = in_elem_t'(rand_bits(IN_W));
            end
        end
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Blocks go out in block-row-major order with optional idle cycles before each beat
    task automatic drive_matrix(input int gap_max);
        int gap;
        int br;
        int bc;
        for (int k = 0; k < BLKS_PER_MAT; k++) begin
            gap = (gap_max > 0) ? int'(rand_bits(2)) % (gap_max + 1) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                in_first = 1'b0;
                in_last  = 1'b0;
            end
            br = k / BLKS_PER_ROW;
            bc = k % BLKS_PER_ROW;
            @(posedge clk);
            #1;
            in_valid    = 1'b1;
            in_first    = (k == 0);
            in_last     = (k == BLKS_PER_MAT - 1);
            in_block[0] = mat_in[2*br][2*bc];
            in_block[1] = mat_in[2*br][2*bc+1];
            in_block[2] = mat_in[2*br+1][2*bc];
            in_block[3] = mat_in[2*br+1][2*bc+1];
        end
        build_expected();
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
        in_block = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fill_directed();
        drive_matrix(0);
        // Even matrices run back to back and odd ones get idle gaps
        for (int m = 1; m < NUM_MATS; m++) begin
            fill_random();
            drive_matrix((m % 2 == 0) ? 0 : 3);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
        while (exp_rows.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

    // Outputs settle after the rising edge and are compared at the falling edge
    always @(negedge clk) begin
        row_t     er;
        sum_t     es;
        row_idx_t ei;
        if (out_valid === 1'b1) begin
            if (exp_rows.size() == 0) begin
                $display("Row output at %0t ns with no matrix pending", $time);
                abort_run();
            end else begin
                er = exp_rows.pop_front();
                es = exp_sums.pop_front();
                ei = exp_idx.pop_front();
                check_equal(128'(out_index), 128'(ei), "row index");
                check_equal(128'(out_row), 128'(er), $sformatf("row %0d data", ei));
                check_equal(128'(out_sum), 128'(es), $sformatf("row %0d sum", ei));
                check_equal(128'(out_last), 128'(ei == row_idx_t'(MAT_N - 1)),
                            $sformatf("row %0d last flag", ei));
            end
        end else begin
            check_equal(128'(out_valid), 128'(1'b0), "out_valid low when idle");
        end
    end

    initial begin
        #(LIMIT_MATS * 64 * CLK_NS + RST_CYCLES * CLK_NS);
        $display("Timeout: the run did not finish, the DUT seems to hang");
        abort_run();
    end

endmodule

`default_nettype wire

/* testbench/b2r_assert.sv */
// Concurrent assertions on the block to row buffer
// Bound into block_to_row_buffer
`timescale 1ns/1ps
`default_nettype none

module b2r_assert (
    input logic                                    clk,
    input logic                                    rst_n,
    input logic                                    blk_valid,
    input logic                                    blk_first,
    input logic                                    blk_last,
    input logic                                    row_valid,
    input logic                                    row_first,
    input logic                                    row_last,
    input logic [$clog2(conv_pkg::BLKS_PER_MAT):0] fill_cnt
);
    import conv_pkg::*;

    // Frame markers on the block side
    a_blk_first_valid: assert property (@(posedge clk) disable iff (!rst_n)
        blk_first |-> blk_valid)
        else $error("Block first marker without valid");

    a_blk_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        blk_last |-> blk_valid)
        else $error("Block last marker without valid");

    // Drain runs eight rows without a gap
    a_row_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (row_valid && !row_last) |=> row_valid)
        else $error("Row valid dropped before the last row");

    a_row_len: assert property (@(posedge clk) disable iff (!rst_n)
        (row_valid && row_first) |-> ##7 (row_valid && row_last))
        else $error("Last row not seven cycles after the first row");

    // Fill never goes past one matrix
    a_fill_bound: assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid |-> (fill_cnt != ($clog2(BLKS_PER_MAT) + 1)'(BLKS_PER_MAT)))
        else $error("Block written into a full bank");

endmodule

bind block_to_row_buffer b2r_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .blk_valid (blk.valid),
    .blk_first (blk.first),
    .blk_last  (blk.last),
    .row_valid (row.valid),
    .row_first (row.first),
    .row_last  (row.last),
    .fill_cnt  (fill_cnt)
);

`default_nettype wire

/* logic/b2r_top.sv */
// Top level of the block to row converter
// Quantizer, ping-pong reorder buffer and row summer
`timescale 1ns/1ps
`default_nettype none

module b2r_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_first,
    input  logic                in_last,
    input  conv_pkg::in_block_t in_block,
    output logic                out_valid,
    output conv_pkg::row_t      out_row,
    output conv_pkg::sum_t      out_sum,
    output conv_pkg::row_idx_t  out_index,
    output logic                out_last
);
    import conv_pkg::*;

    beat_if #(.payload_t(block_t)) blk ();
    beat_if #(.payload_t(row_t))   row ();

    block_quantizer u_quant (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_first (in_first),
        .in_last  (in_last),
        .in_block (in_block),
        .blk      (blk.src)
    );

    block_to_row_buffer u_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .blk   (blk.dst),
        .row   (row.src)
    );

    row_summer u_summer (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row.dst),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_sum   (out_sum),
        .out_index (out_index),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

/* logic/row_summer.sv */
// Row consumer, attaches element sum and row index
// One register stage from row beat to outputs
`timescale 1ns/1ps
`default_nettype none

module row_summer (
    input  logic               clk,
    input  logic               rst_n,
    beat_if.dst                row,
    output logic               out_valid,
    output conv_pkg::row_t     out_row,
    output conv_pkg::sum_t     out_sum,
    output conv_pkg::row_idx_t out_index,
    output logic               out_last
);
    import conv_pkg::*;

    sum_t     row_sum;
    row_idx_t idx_cnt;
    row_idx_t idx_now;

    // Signed sum over all columns
    always_comb begin
        row_sum = '0;
        for (int c = 0; c < MAT_N; c++) begin
            row_sum = row_sum + sum_t'($signed(row.payload[c]));
        end
    end

    assign idx_now = row.first ? '0 : idx_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            idx_cnt   <= '0;
        end else begin
            out_valid <= row.valid;
            out_last  <= row.valid && row.last;
            if (row.valid) begin
                idx_cnt <= idx_now + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row.valid) begin
            out_row   <= row.payload;
            out_sum   <= row_sum;
            out_index <= idx_now;
        end
    end

endmodule

`default_nettype wire

/* logic/block_to_row_buffer.sv */
// Ping-pong block to row reorder buffer
// Even and odd rows in separate lane RAMs, two banks each
`timescale 1ns/1ps
`default_nettype none

module block_to_row_buffer (
    input  logic clk,
    input  logic rst_n,
    beat_if.dst  blk,
    beat_if.src  row
);
    import conv_pkg::*;

    // Fill side
    logic [$clog2(BLKS_PER_MAT):0]   fill_cnt;
    logic                            fill_bank;
    logic [$clog2(BLKS_PER_MAT)-1:0] blk_idx;
    logic [$clog2(BLKS_PER_ROW)-1:0] blk_row;
    logic [$clog2(BLKS_PER_ROW)-1:0] blk_col;
    logic [BLKS_PER_ROW-1:0]         wr_en;
    logic [$clog2(MAT_N)-1:0]        waddr;
    pair_t [BLKS_PER_ROW-1:0]        even_wdata;
    pair_t [BLKS_PER_ROW-1:0]        odd_wdata;

    // Drain side
    logic                     rd_active;
    logic [$clog2(MAT_N)-1:0] rd_row;
    logic [$clog2(MAT_N)-1:0] raddr;
    logic                     rd_valid_q;
    logic                     rd_first_q;
    logic                     rd_last_q;
    logic                     rd_par_q;
    pair_t [BLKS_PER_ROW-1:0] even_rdata;
    pair_t [BLKS_PER_ROW-1:0] odd_rdata;

    // Block position, restarts at first
    assign blk_idx            = blk.first ? '0 : fill_cnt[$clog2(BLKS_PER_MAT)-1:0];
    assign {blk_row, blk_col} = blk_idx;
    assign waddr              = {fill_bank, blk_row};

    always_comb begin
        wr_en = '0;
        if (blk.valid) begin
            wr_en[blk_col] = 1'b1;
        end
    end

    // Top pair to the even row, bottom pair to the odd row
    always_comb begin
        for (int l = 0; l < BLKS_PER_ROW; l++) begin
            even_wdata[l] = blk.payload[BLK-1:0];
            odd_wdata[l]  = blk.payload[BLK*BLK-1:BLK];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            fill_bank <= 1'b0;
        end else if (blk.valid) begin
            if (blk.last) begin
                fill_cnt  <= '0;
                fill_bank <= ~fill_bank;
            end else begin
                fill_cnt <= {1'b0, blk_idx} + 1'b1;
            end
        end
    end

    // Drain reads the bank that is not filling
    assign raddr = {~fill_bank, rd_row[$clog2(MAT_N)-1:1]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active  <= 1'b0;
            rd_row     <= '0;
            rd_valid_q <= 1'b0;
            rd_first_q <= 1'b0;
            rd_last_q  <= 1'b0;
            rd_par_q   <= 1'b0;
        end else begin
            rd_valid_q <= rd_active;
            rd_first_q <= (rd_row == '0);
            rd_last_q  <= (rd_row == ($clog2(MAT_N))'(MAT_N - 1));
            rd_par_q   <= rd_row[0];
            if (blk.valid && blk.last) begin
                rd_active <= 1'b1;
                rd_row    <= '0;
            end else if (rd_active) begin
                rd_row <= rd_row + 1'b1;
                if (rd_row == ($clog2(MAT_N))'(MAT_N - 1)) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    lane_ram #(
        .lane_t (pair_t),
        .LANES  (BLKS_PER_ROW),
        .DEPTH  (MAT_N)
    ) u_even_ram (
        .clk   (clk),
        .we    (wr_en),
        .waddr (waddr),
        .wdata (even_wdata),
        .raddr (raddr),
        .rdata (even_rdata)
    );

    lane_ram #(
        .lane_t (pair_t),
        .LANES  (BLKS_PER_ROW),
        .DEPTH  (MAT_N)
    ) u_odd_ram (
        .clk   (clk),
        .we    (wr_en),
        .waddr (waddr),
        .wdata (odd_wdata),
        .raddr (raddr),
        .rdata (odd_rdata)
    );

    // Lane order matches column order, so the RAM word is the row
    assign row.valid   = rd_valid_q;
    assign row.first   = rd_valid_q && rd_first_q;
    assign row.last    = rd_valid_q && rd_last_q;
    assign row.payload = rd_par_q ? odd_rdata : even_rdata;

endmodule

`default_nettype wire

/* logic/lane_ram.sv */
// Simple dual-port RAM, one write and one read port
// Per-lane write enables, registered read data
`timescale 1ns/1ps
`default_nettype none

module lane_ram #(
    parameter type lane_t = logic [7:0],
    parameter int  LANES  = 4,
    parameter int  DEPTH  = 8
) (
    input  logic                     clk,
    input  logic [LANES-1:0]         we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  lane_t [LANES-1:0]        wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output lane_t [LANES-1:0]        rdata
);

    lane_t [LANES-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we[l]) begin
                mem[waddr][l] <= wdata[l];
            end
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* logic/block_quantizer.sv */
// Block producer, rounds Q8.16 elements to Q8.8 with saturation
// One register stage between input and block beat
`timescale 1ns/1ps
`default_nettype none

module block_quantizer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_first,
    input  logic                in_last,
    input  conv_pkg::in_block_t in_block,
    beat_if.src                 blk
);
    import conv_pkg::*;

    block_t q_block;

    // Round half up, then clamp to the signed 16-bit range
    function automatic elem_t quantize(input in_elem_t x);
        logic signed [IN_W:0]            rounded;
        logic signed [IN_W-FRAC_SHIFT:0] shifted;
        rounded = (IN_W+1)'(x) + (IN_W+1)'(1 << (FRAC_SHIFT - 1));
        // Top bits of the rounded value, same as an arithmetic shift
        shifted = rounded[IN_W:FRAC_SHIFT];
        if (shifted[IN_W-FRAC_SHIFT] == shifted[ELEM_W-1]) begin
            quantize = shifted[ELEM_W-1:0];
        end else if (!shifted[IN_W-FRAC_SHIFT]) begin
            quantize = {1'b0, {(ELEM_W-1){1'b1}}};
        end else begin
            quantize = {1'b1, {(ELEM_W-1){1'b0}}};
        end
    endfunction

    always_comb begin
        for (int e = 0; e < BLK*BLK; e++) begin
            q_block[e] = quantize(in_block[e]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk.valid <= 1'b0;
            blk.first <= 1'b0;
            blk.last  <= 1'b0;
        end else begin
            blk.valid <= in_valid;
            blk.first <= in_valid && in_first;
            blk.last  <= in_valid && in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            blk.payload <= q_block;
        end
    end

endmodule

`default_nettype wire

/* logic/beat_if.sv */
// Strobe-framed beat interface with a typed payload
`timescale 1ns/1ps
`default_nettype none

interface beat_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     first;
    logic     last;
    payload_t payload;

    modport src (output valid, output first, output last, output payload);

    modport dst (input valid, input first, input last, input payload);

endinterface

`default_nettype wire

/* logic/conv_pkg.sv */
// Matrix and block size constants
// Fixed-point element, block, row and sum types for the reorder path
`default_nettype none

package conv_pkg;

    // Output element Q8.8, input element Q8.16
    localparam int ELEM_W     = 16;
    localparam int IN_W       = 24;
    localparam int FRAC_SHIFT = 8;

    // Matrix side and block side
    localparam int MAT_N        = 8;
    localparam int BLK          = 2;
    localparam int BLKS_PER_ROW = MAT_N / BLK;
    localparam int BLKS_PER_MAT = BLKS_PER_ROW * BLKS_PER_ROW;

    typedef logic signed [IN_W-1:0]   in_elem_t;
    typedef logic signed [ELEM_W-1:0] elem_t;

    // Element order (0,0) (0,1) (1,0) (1,1), lowest bits first
    typedef in_elem_t [BLK*BLK-1:0] in_block_t;
    typedef elem_t    [BLK*BLK-1:0] block_t;

    // Column c at element c
    typedef elem_t [MAT_N-1:0] row_t;

    // One RAM lane, half of a block row
    typedef elem_t [BLK-1:0] pair_t;

    // Eight Q8.8 values summed without overflow
    typedef logic signed [ELEM_W+$clog2(MAT_N)-1:0] sum_t;

    typedef logic [$clog2(MAT_N)-1:0] row_idx_t;

endpackage

`default_nettype wire
